/* Makefile */
SIM      := verilator
TOP      := pkt_dispatch_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
VFLAGS   := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM_ARGS := +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/pkt_dispatch_macros.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

/* design/core_msg_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_dispatch_macros.svh"

module core_msg_arbiter
  import pkt_dispatch_pkg::*;
(
  input  logic                   logic_clk,
  input  logic                   rst,
  input  msg_word_t              core_msg_data [`CORE_COUNT],
  input  logic [`CORE_COUNT-1:0] core_msg_valid,
  output core_msg_t              release_msg,
  output logic                   release_valid
);

  msg_word_t              q_data [`CORE_COUNT];
  logic [`CORE_COUNT-1:0] q_not_empty;
  logic [`CORE_COUNT-1:0] q_pop;
  core_idx_t              rr_ptr;
  core_idx_t              grant_core;
  logic                   grant_valid;

  for (genvar i = 0; i < `CORE_COUNT; i++) begin : g_core_q
    assign q_pop[i] = grant_valid && (grant_core == core_idx_t'(i));

    sync_fifo #(
      .payload_t(msg_word_t),
      .DEPTH    (`MSG_FIFO_DEPTH)
    ) msg_q (
      .logic_clk(logic_clk),
      .rst      (rst),
      .push     (core_msg_valid[i]),
      .push_data(core_msg_data[i]),
      .pop      (q_pop[i]),
      .pop_data (q_data[i]),
      .not_empty(q_not_empty[i]),
      .full     ()
    );
  end

  // first non-empty queue after the last one served
  always_comb begin
    core_idx_t idx;
    grant_valid = 1'b0;
    grant_core  = rr_ptr;
    for (int k = `CORE_COUNT; k >= 1; k--) begin
      idx = core_idx_t'(rr_ptr + k);
      if (q_not_empty[idx]) begin
        grant_valid = 1'b1;
        grant_core  = idx;
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      release_valid <= 1'b0;
      // core 0 goes first after reset
      rr_ptr        <= core_idx_t'(`CORE_COUNT - 1);
    end else begin
      release_valid <= grant_valid;
      if (grant_valid) begin
        rr_ptr <= grant_core;
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    if (grant_valid) begin
      release_msg.core <= grant_core;
      release_msg.msg  <= q_data[grant_core];
    end
  end

endmodule

`default_nettype wire

/* design/dispatch_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_dispatch_macros.svh"

module dispatch_fsm
  import pkt_dispatch_pkg::*;
(
  input  logic       logic_clk,
  input  logic       rst,
  input  logic       frames_pending,
  input  logic       free_found,
  input  core_idx_t  free_core,
  input  slot_idx_t  free_slot,
  input  slot_base_t free_base,
  input  logic       desc_full,
  output logic       alloc_valid,
  output core_idx_t  alloc_core,
  output slot_idx_t  alloc_slot,
  output logic       frame_taken,
  output logic       desc_push,
  output rx_desc_t   desc_data
);

  // every slot advertises the full step as its length, 2048 bytes
  localparam logic [`LEN_WIDTH-1:0] MAX_PKT_LEN =
    {{(`LEN_WIDTH - `SLOT_ADDR_EFF){1'b0}}, `SLOT_ADDR_STEP} << `SLOT_LEAD_ZERO;
  localparam logic [`CORE_ADDR_WIDTH-1:0] WR_OFFSET = `RX_WRITE_OFFSET;

  typedef enum logic [1:0] {
    IDLE,
    ALLOC,
    PUSH
  } state_t;

  state_t                      state;
  core_idx_t                   lat_core;
  slot_idx_t                   lat_slot;
  slot_base_t                  lat_base;
  rx_desc_t                    desc_reg;
  logic [`CORE_ADDR_WIDTH-1:0] win_addr;

  // slot goes busy at the end of this cycle
  assign alloc_valid = (state == IDLE) && frames_pending && free_found;
  assign alloc_core  = free_core;
  assign alloc_slot  = free_slot;

  assign desc_push   = (state == PUSH) && !desc_full;
  // credit is returned only once the descriptor is queued
  assign frame_taken = desc_push;
  assign desc_data   = desc_reg;

  // base back to a byte address inside the core window
  assign win_addr =
    ({{(`CORE_ADDR_WIDTH - `SLOT_ADDR_EFF){1'b0}}, lat_base} << `SLOT_LEAD_ZERO) + WR_OFFSET;

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (alloc_valid) begin
            state <= ALLOC;
          end
        end
        ALLOC: begin
          state <= PUSH;
        end
        PUSH: begin
          if (desc_push) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge logic_clk) begin
    if (alloc_valid) begin
      lat_core <= free_core;
      lat_slot <= free_slot;
      lat_base <= free_base;
    end
    if (state == ALLOC) begin
      desc_reg.addr     <= {lat_core, win_addr};
      desc_reg.len      <= MAX_PKT_LEN;
      desc_reg.tag.core <= lat_core;
      desc_reg.tag.slot <= lat_slot;
    end
  end

endmodule

`default_nettype wire

/* design/frame_credit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_credit_counter (
  input  logic logic_clk,
  input  logic rst,
  input  logic rx_frame_good,
  input  logic frame_taken,
  output logic frames_pending
);

  localparam int CNT_WIDTH = 8;

  logic [CNT_WIDTH-1:0] count;

  // saturates at both ends
  always_ff @(posedge logic_clk) begin
    if (rst) begin
      count <= '0;
    end else if (rx_frame_good && !frame_taken) begin
      if (count != '1) begin
        count <= count + 1'b1;
      end
    end else if (!rx_frame_good && frame_taken) begin
      if (count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

  // a frame and a take in one cycle cancel out
  assign frames_pending = (count != '0);

endmodule

`default_nettype wire

/* design/pkt_dispatch_macros.svh */
`ifndef PKT_DISPATCH_MACROS_SVH
`define PKT_DISPATCH_MACROS_SVH

// system shape
`define CORE_COUNT 4
`define SLOT_COUNT 4

// core memory window and slot placement
`define CORE_ADDR_WIDTH 16
`define SLOT_LEAD_ZERO 8
// stored base drops the top window bit and the leading zeros
`define SLOT_ADDR_EFF (`CORE_ADDR_WIDTH - 1 - `SLOT_LEAD_ZERO)

// reset slot layout, the step also sets the max packet length
`define FIRST_SLOT_ADDR 7'h40
`define SLOT_ADDR_STEP 7'h08

// receive data lands this far into the slot
`define RX_WRITE_OFFSET 8'h08

`define LEN_WIDTH 16

// queue depths
`define MSG_FIFO_DEPTH 4
`define DESC_FIFO_DEPTH 4

`endif

/* design/pkt_dispatch_pkg.sv */
`default_nettype none

`include "pkt_dispatch_macros.svh"

package pkt_dispatch_pkg;

  typedef logic [$clog2(`CORE_COUNT)-1:0] core_idx_t;
  typedef logic [$clog2(`SLOT_COUNT)-1:0] slot_idx_t;

  // core number on top of a core-window address
  typedef logic [`CORE_ADDR_WIDTH+$clog2(`CORE_COUNT)-1:0] desc_addr_t;

  typedef logic [`SLOT_ADDR_EFF-1:0] slot_base_t;
  typedef logic [63:0] msg_word_t;

  typedef struct packed {
    core_idx_t core;
    slot_idx_t slot;
  } desc_tag_t;

  typedef struct packed {
    desc_addr_t            addr;
    logic [`LEN_WIDTH-1:0] len;
    desc_tag_t             tag;
  } rx_desc_t;

  // host write into the slot base table
  typedef struct packed {
    slot_idx_t  slot;
    slot_base_t base;
  } slot_wr_t;

  typedef struct packed {
    core_idx_t core;
    msg_word_t msg;
  } core_msg_t;

endpackage

`default_nettype wire

/* design/pkt_dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_dispatch_macros.svh"

module pkt_dispatch_top
  import pkt_dispatch_pkg::*;
(
  input  logic                   logic_clk,
  input  logic                   rst,
  input  logic                   rx_frame_good,
  input  slot_wr_t               slot_wr,
  input  logic                   slot_wr_valid,
  input  msg_word_t              core_msg_data [`CORE_COUNT],
  input  logic [`CORE_COUNT-1:0] core_msg_valid,
  output rx_desc_t               rx_desc,
  output logic                   rx_desc_valid,
  input  logic                   rx_desc_ready
);

  logic       frames_pending;
  logic       frame_taken;
  logic       free_found;
  core_idx_t  free_core;
  slot_idx_t  free_slot;
  slot_base_t free_base;
  logic       alloc_valid;
  core_idx_t  alloc_core;
  slot_idx_t  alloc_slot;
  core_msg_t  release_msg;
  logic       release_valid;
  logic       desc_push;
  rx_desc_t   desc_data;
  logic       desc_full;
  logic       desc_pop;

  assign desc_pop = rx_desc_valid && rx_desc_ready;

  frame_credit_counter credit_cnt (
    .logic_clk     (logic_clk),
    .rst           (rst),
    .rx_frame_good (rx_frame_good),
    .frame_taken   (frame_taken),
    .frames_pending(frames_pending)
  );

  slot_table slots (
    .logic_clk    (logic_clk),
    .rst          (rst),
    .slot_wr      (slot_wr),
    .slot_wr_valid(slot_wr_valid),
    .alloc_valid  (alloc_valid),
    .alloc_core   (alloc_core),
    .alloc_slot   (alloc_slot),
    .release_msg  (release_msg),
    .release_valid(release_valid),
    .free_found   (free_found),
    .free_core    (free_core),
    .free_slot    (free_slot),
    .free_base    (free_base)
  );

  core_msg_arbiter msg_arbiter (
    .logic_clk     (logic_clk),
    .rst           (rst),
    .core_msg_data (core_msg_data),
    .core_msg_valid(core_msg_valid),
    .release_msg   (release_msg),
    .release_valid (release_valid)
  );

  dispatch_fsm dispatcher (
    .logic_clk     (logic_clk),
    .rst           (rst),
    .frames_pending(frames_pending),
    .free_found    (free_found),
    .free_core     (free_core),
    .free_slot     (free_slot),
    .free_base     (free_base),
    .desc_full     (desc_full),
    .alloc_valid   (alloc_valid),
    .alloc_core    (alloc_core),
    .alloc_slot    (alloc_slot),
    .frame_taken   (frame_taken),
    .desc_push     (desc_push),
    .desc_data     (desc_data)
  );

  // head of this queue is the descriptor output
  sync_fifo #(
    .payload_t(rx_desc_t),
    .DEPTH    (`DESC_FIFO_DEPTH)
  ) desc_q (
    .logic_clk(logic_clk),
    .rst      (rst),
    .push     (desc_push),
    .push_data(desc_data),
    .pop      (desc_pop),
    .pop_data (rx_desc),
    .not_empty(rx_desc_valid),
    .full     (desc_full)
  );

endmodule

`default_nettype wire

/* design/slot_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_dispatch_macros.svh"

module slot_table
  import pkt_dispatch_pkg::*;
(
  input  logic       logic_clk,
  input  logic       rst,
  input  slot_wr_t   slot_wr,
  input  logic       slot_wr_valid,
  input  logic       alloc_valid,
  input  core_idx_t  alloc_core,
  input  slot_idx_t  alloc_slot,
  input  core_msg_t  release_msg,
  input  logic       release_valid,
  output logic       free_found,
  output core_idx_t  free_core,
  output slot_idx_t  free_slot,
  output slot_base_t free_base
);

  slot_base_t              base [`SLOT_COUNT];
  logic [`SLOT_COUNT-1:0]  busy [`CORE_COUNT];
  slot_idx_t               rel_slot;

  // only the low bits of a message name the slot
  assign rel_slot = release_msg.msg[$bits(slot_idx_t)-1:0];

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      for (int s = 0; s < `SLOT_COUNT; s++) begin
        base[s] <= slot_base_t'(`FIRST_SLOT_ADDR + s * `SLOT_ADDR_STEP);
      end
    end else if (slot_wr_valid) begin
      base[slot_wr.slot] <= slot_wr.base;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      for (int c = 0; c < `CORE_COUNT; c++) begin
        busy[c] <= '0;
      end
    end else begin
      // freeing an idle slot leaves it idle
      if (release_valid) begin
        busy[release_msg.core][rel_slot] <= 1'b0;
      end
      if (alloc_valid) begin
        busy[alloc_core][alloc_slot] <= 1'b1;
      end
    end
  end

  // scan downwards so the lowest core, then lowest slot, is kept
  always_comb begin
    free_found = 1'b0;
    free_core  = '0;
    free_slot  = '0;
    for (int c = `CORE_COUNT - 1; c >= 0; c--) begin
      for (int s = `SLOT_COUNT - 1; s >= 0; s--) begin
        if (!busy[c][s]) begin
          free_found = 1'b1;
          free_core  = core_idx_t'(c);
          free_slot  = slot_idx_t'(s);
        end
      end
    end
  end

  assign free_base = base[free_slot];

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     logic_clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     not_empty,
  output logic     full
);

  localparam int PTR_W = $clog2(DEPTH);

  payload_t       mem [DEPTH];
  // extra top bit tells full from empty
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic           do_push;
  logic           do_pop;

  assign not_empty = (wr_ptr != rd_ptr);
  assign full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  assign do_push = push && !full;
  assign do_pop  = pop && not_empty;

  // head word is visible without a pop
  assign pop_data = mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    if (do_push) begin
      mem[wr_ptr[PTR_W-1:0]] <= push_data;
    end
  end

endmodule

`default_nettype wire

/* dv/pkt_dispatch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_dispatch_checker
  import pkt_dispatch_pkg::*;
(
  input logic     logic_clk,
  input logic     rst,
  input rx_desc_t rx_desc,
  input logic     rx_desc_valid,
  input logic     rx_desc_ready
);

  // number of failed assertions so far
  int assert_errors = 0;

  // descriptor queue comes out of reset empty
  reset_clears_valid: assert property (@(posedge logic_clk) rst |=> !rx_desc_valid)
    else begin
      assert_errors++;
      $error("rx_desc_valid high right after reset");
    end

  stalled_desc_holds: assert property (@(posedge logic_clk) disable iff (rst)
    rx_desc_valid && !rx_desc_ready |=> rx_desc_valid && $stable(rx_desc))
    else begin
      assert_errors++;
      $error("rx_desc changed or dropped while stalled");
    end

endmodule

bind pkt_dispatch_top pkt_dispatch_checker checks0 (
  .logic_clk    (logic_clk),
  .rst          (rst),
  .rx_desc      (rx_desc),
  .rx_desc_valid(rx_desc_valid),
  .rx_desc_ready(rx_desc_ready)
);

`default_nettype wire

/* dv/pkt_dispatch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_dispatch_macros.svh"

module pkt_dispatch_tb
  import pkt_dispatch_pkg::*;
();

  localparam logic [31:0] SEED = 32'h8bf3_38ab;
  // stimulus takes roughly 2000 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  typedef logic [`LEN_WIDTH-1:0] len_t;
  typedef logic [`CORE_ADDR_WIDTH-1:0] win_addr_t;
  typedef logic [`CORE_COUNT-1:0] core_mask_t;

  logic                   logic_clk;
  logic                   rst;
  logic                   rx_frame_good;
  slot_wr_t               slot_wr;
  logic                   slot_wr_valid;
  msg_word_t              core_msg_data [`CORE_COUNT];
  core_mask_t             core_msg_valid;
  rx_desc_t               rx_desc;
  logic                   rx_desc_valid;
  logic                   rx_desc_ready;
  logic                   bp_enable;

  // reference model
  bit                     busy_m [`CORE_COUNT][`SLOT_COUNT];
  slot_base_t             base_m [`SLOT_COUNT];
  rx_desc_t               exp_q [$];
  int                     pending_m;
  int                     error_count;
  int                     check_count;
  int                     cycle_count;

  pkt_dispatch_top dut0 (
    .logic_clk     (logic_clk),
    .rst           (rst),
    .rx_frame_good (rx_frame_good),
    .slot_wr       (slot_wr),
    .slot_wr_valid (slot_wr_valid),
    .core_msg_data (core_msg_data),
    .core_msg_valid(core_msg_valid),
    .rx_desc       (rx_desc),
    .rx_desc_valid (rx_desc_valid),
    .rx_desc_ready (rx_desc_ready)
  );

  initial begin
    logic_clk = 1'b0;
    forever #5 logic_clk = ~logic_clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge logic_clk);
      cycle_count++;
    end
    $display("run stopped by the timeout after %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL @%0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  function automatic rx_desc_t predict_desc(input core_idx_t c, input slot_idx_t s);
    rx_desc_t  d;
    win_addr_t win;
    // slot base back to a byte address, data starts past the write offset
    win = (win_addr_t'(base_m[s]) << `SLOT_LEAD_ZERO) + win_addr_t'(`RX_WRITE_OFFSET);
    d.addr     = {c, win};
    // every slot holds a 2 KiB packet
    d.len      = len_t'(2048);
    d.tag.core = c;
    d.tag.slot = s;
    return d;
  endfunction

  // lowest free core first, then lowest free slot
  function automatic bit take_free_slot();
    for (int c = 0; c < `CORE_COUNT; c++) begin
      for (int s = 0; s < `SLOT_COUNT; s++) begin
        if (!busy_m[c][s]) begin
          busy_m[c][s] = 1'b1;
          exp_q.push_back(predict_desc(core_idx_t'(c), slot_idx_t'(s)));
          return 1'b1;
        end
      end
    end
    return 1'b0;
  endfunction

  function automatic int count_free();
    int n;
    n = 0;
    for (int c = 0; c < `CORE_COUNT; c++) begin
      for (int s = 0; s < `SLOT_COUNT; s++) begin
        if (!busy_m[c][s]) begin
          n++;
        end
      end
    end
    return n;
  endfunction

  task automatic tick();
    @(posedge logic_clk);
    #1;
  endtask

  task automatic send_frames(input int n);
    for (int i = 0; i < n; i++) begin
      rx_frame_good = 1'b1;
      if (!take_free_slot()) begin
        pending_m++;
      end
      tick();
      rx_frame_good = 1'b0;
      repeat ($urandom_range(2)) tick();
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      tick();
    end
    repeat (20) tick();
  endtask

  task automatic write_slot_base();
    slot_wr.slot  = slot_idx_t'($urandom_range(`SLOT_COUNT - 1));
    slot_wr.base  = slot_base_t'($urandom());
    slot_wr_valid = 1'b1;
    base_m[slot_wr.slot] = slot_wr.base;
    tick();
    slot_wr_valid = 1'b0;
    repeat (20) tick();
  endtask

  // every core in the mask frees one slot on the same cycle
  task automatic send_releases(input core_mask_t cores);
    slot_idx_t s;
    for (int c = 0; c < `CORE_COUNT; c++) begin
      if (cores[c]) begin
        s = slot_idx_t'($urandom_range(`SLOT_COUNT - 1));
        core_msg_data[c] = {$urandom(), $urandom()};
        core_msg_data[c][$bits(slot_idx_t)-1:0] = s;
        busy_m[c][s] = 1'b0;
      end
    end
    core_msg_valid = cores;
    tick();
    core_msg_valid = '0;
    // a frame waiting for a slot takes the freed one
    while (pending_m > 0 && take_free_slot()) begin
      pending_m--;
    end
    repeat (20) tick();
  endtask

  always @(posedge logic_clk) begin
    #1;
    rx_desc_ready = bp_enable ? ($urandom_range(3) != 0) : 1'b1;
  end

  // transfers compared mid-cycle, when valid and ready are settled
  always @(negedge logic_clk) begin
    rx_desc_t exp_d;
    if (!rst && rx_desc_valid && rx_desc_ready) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("FAIL @%0t: descriptor tag 0x%0h with none expected", $time, rx_desc.tag);
      end else begin
        exp_d = exp_q.pop_front();
        check_equal("descriptor tag", 32'(rx_desc.tag), 32'(exp_d.tag));
        check_equal("descriptor addr", 32'(rx_desc.addr), 32'(exp_d.addr));
        check_equal("descriptor len", 32'(rx_desc.len), 32'(exp_d.len));
      end
    end
  end

  initial begin
    int sent;
    int burst;
    int op;
    void'($urandom(SEED));
    rst = 1'b1;
    rx_frame_good = 1'b0;
    slot_wr = '0;
    slot_wr_valid = 1'b0;
    core_msg_valid = '0;
    rx_desc_ready = 1'b1;
    bp_enable = 1'b0;
    pending_m = 0;
    error_count = 0;
    check_count = 0;
    for (int c = 0; c < `CORE_COUNT; c++) begin
      core_msg_data[c] = '0;
      for (int s = 0; s < `SLOT_COUNT; s++) begin
        busy_m[c][s] = 1'b0;
      end
    end
    for (int s = 0; s < `SLOT_COUNT; s++) begin
      base_m[s] = slot_base_t'(`FIRST_SLOT_ADDR + s * `SLOT_ADDR_STEP);
    end
    repeat (5) @(posedge logic_clk);
    #1;
    rst = 1'b0;
    // quiet period, no descriptor may show up
    repeat (30) tick();
    sent = 0;
    while (sent < `CORE_COUNT * `SLOT_COUNT) begin
      burst = int'($urandom_range(1, 8));
      if (burst > `CORE_COUNT * `SLOT_COUNT - sent) begin
        burst = `CORE_COUNT * `SLOT_COUNT - sent;
      end
      send_frames(burst);
      sent += burst;
      wait_drain();
    end
    // all slots busy, this frame has to wait
    send_frames(1);
    repeat (40) tick();
    send_releases(core_mask_t'(1 << $urandom_range(`CORE_COUNT - 1)));
    wait_drain();
    bp_enable = 1'b1;
    for (int i = 0; i < 24; i++) begin
      op = int'($urandom_range(2));
      if (op == 0 && count_free() > 0) begin
        send_frames(int'($urandom_range(1, count_free())));
        wait_drain();
      end else if (op == 1) begin
        write_slot_base();
      end else begin
        send_releases(core_mask_t'($urandom_range(1, (1 << `CORE_COUNT) - 1)));
      end
    end
    wait_drain();
    // nothing left in the descriptor queue once every frame is served
    check_equal("rx_desc_valid at end", 32'(rx_desc_valid), 32'd0);
    $display("checks %0d, errors %0d, assertion failures %0d",
             check_count, error_count, dut0.checks0.assert_errors);
    if (error_count == 0 && dut0.checks0.assert_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/pkt_dispatch_pkg.sv
design/sync_fifo.sv
design/frame_credit_counter.sv
design/slot_table.sv
design/core_msg_arbiter.sv
design/dispatch_fsm.sv
design/pkt_dispatch_top.sv
dv/pkt_dispatch_checker.sv
dv/pkt_dispatch_tb.sv
